// File: logic/pcie_cfg.svh
// PCIe endpoint configuration
// BAR0 aperture and register map of the completer core

`ifndef PCIE_CFG_SVH
`define PCIE_CFG_SVH

// byte-address bits decoded inside BAR0
`define PCIE_BAR0_APERTURE 12

// value returned by the read-only ID register
`define PCIE_REG_ID 32'hc0de_0a01

// register map, dword offsets within BAR0
`define PCIE_REG_ADDR_ID        10'd0
`define PCIE_REG_ADDR_SCRATCH   10'd1
`define PCIE_REG_ADDR_WR_COUNT  10'd2
`define PCIE_REG_ADDR_ERR_COUNT 10'd3

`endif

// File: logic/pcie_pkg.sv
// PCIe completer types
// request beat, decoded request and completion beat formats

`include "pcie_cfg.svh"

package pcie_pkg;

    // request type field of the CQ descriptor
    typedef enum logic [3:0] {
        req_mem_read  = 4'd0,
        req_mem_write = 4'd1,
        req_io_read   = 4'd2,
        req_io_write  = 4'd3
    } req_type_e;

    // completion status codes
    localparam logic [2:0] cpl_status_sc = 3'd0;
    localparam logic [2:0] cpl_status_ur = 3'd1;

    // one completer request beat, descriptor plus one data dword
    typedef struct packed {
        logic [61:0] addr;
        logic [10:0] dword_count;
        req_type_e   req_type;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [2:0]  bar_id;
        logic [3:0]  first_be;
        logic [31:0] data;
    } cq_beat_t;

    // request after decode, as seen by the register file and completion side
    typedef struct packed {
        logic                              is_read;
        logic                              is_write;
        logic                              unsupported;
        logic [`PCIE_BAR0_APERTURE-3:0]    reg_index;
        logic [3:0]                        byte_en;
        logic [31:0]                       wdata;
        logic [15:0]                       requester_id;
        logic [7:0]                        tag;
        logic [6:0]                        lower_addr;
    } req_t;

    // one completer completion beat
    typedef struct packed {
        logic [6:0]  lower_addr;
        logic [12:0] byte_count;
        logic [10:0] dword_count;
        logic [2:0]  status;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [31:0] data;
    } cc_beat_t;

endpackage

// File: logic/pcie_cq_decode.sv
// PCIe completer request decoder
// accepts CQ beats, classifies them and issues one strobe per request

`timescale 1ns/10ps

`include "pcie_cfg.svh"

module pcie_cq_decode (
    input  logic               clk,
    input  logic               rst_n,

    // completer request stream
    input  pcie_pkg::cq_beat_t cq_beat,
    input  logic               cq_valid,
    output logic               cq_ready,

    // completion side still owes or holds a completion
    input  logic               cpl_busy,

    // decoded request
    output pcie_pkg::req_t     req,
    output logic               req_stb,

    output logic               status_error_uncor
);

    import pcie_pkg::*;

    logic cq_fire;
    logic type_ok;
    logic bar_ok;
    logic len_ok;
    logic addr_ok;
    req_t req_next;

    // stall new requests while a completion is outstanding
    assign cq_ready = ~cpl_busy;
    assign cq_fire  = cq_valid & cq_ready;

    always_comb begin
        type_ok = (cq_beat.req_type == req_mem_read) ||
                  (cq_beat.req_type == req_mem_write);
        bar_ok  = (cq_beat.bar_id == 3'd0);
        len_ok  = (cq_beat.dword_count == 11'd1);
        // upper dword address bits must be clear to hit BAR0
        addr_ok = (cq_beat.addr[61:`PCIE_BAR0_APERTURE-2] == '0);

        // only writes are posted, everything else is owed a completion
        req_next.is_write     = (cq_beat.req_type == req_mem_write) ||
                                (cq_beat.req_type == req_io_write);
        req_next.is_read      = ~req_next.is_write;
        req_next.unsupported  = ~(type_ok & bar_ok & len_ok & addr_ok);

        req_next.reg_index    = cq_beat.addr[`PCIE_BAR0_APERTURE-3:0];
        req_next.byte_en      = cq_beat.first_be;
        req_next.wdata        = cq_beat.data;
        req_next.requester_id = cq_beat.requester_id;
        req_next.tag          = cq_beat.tag;
        // byte address bits 6:0, dword aligned
        req_next.lower_addr   = {cq_beat.addr[4:0], 2'b00};
    end

    // strobe and error pulse, one cycle after the transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_stb            <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            req_stb            <= cq_fire;
            status_error_uncor <= cq_fire & req_next.unsupported;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (cq_fire) begin
            req <= req_next;
        end
    end

endmodule

// File: logic/bar_regs.sv
// BAR0 register file
// ID, scratch and write/error counters behind the decoded request

`timescale 1ns/10ps

`include "pcie_cfg.svh"

module bar_regs (
    input  logic           clk,
    input  logic           rst_n,

    input  pcie_pkg::req_t req,
    input  logic           req_stb,

    // read data for the request currently strobed
    output logic [31:0]    rdata
);

    logic [31:0] scratch;
    logic [31:0] wr_count;
    logic [31:0] err_count;
    logic        wr_en;
    logic        err_en;

    // unsupported writes never reach the registers
    assign wr_en  = req_stb & req.is_write & ~req.unsupported;
    assign err_en = req_stb & req.unsupported;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch   <= '0;
            wr_count  <= '0;
            err_count <= '0;
        end else begin
            if (wr_en && req.reg_index == `PCIE_REG_ADDR_SCRATCH) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.byte_en[i]) begin
                        scratch[8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end

            // counts every supported write, read-only offsets included
            if (wr_en) begin
                wr_count <= wr_count + 32'd1;
            end

            if (err_en) begin
                err_count <= err_count + 32'd1;
            end
        end
    end

    // read mux
    always_comb begin
        case (req.reg_index)
            `PCIE_REG_ADDR_ID:        rdata = `PCIE_REG_ID;
            `PCIE_REG_ADDR_SCRATCH:   rdata = scratch;
            `PCIE_REG_ADDR_WR_COUNT:  rdata = wr_count;
            `PCIE_REG_ADDR_ERR_COUNT: rdata = err_count;
            // unmapped offsets inside the aperture
            default:                  rdata = '0;
        endcase
    end

endmodule

// File: logic/pcie_cc_gen.sv
// PCIe completion builder
// forms one completion per non-posted request and holds it under back-pressure

`timescale 1ns/10ps

module pcie_cc_gen (
    input  logic               clk,
    input  logic               rst_n,

    input  pcie_pkg::req_t     req,
    input  logic               req_stb,
    input  logic [31:0]        rdata,

    output logic               cpl_busy,

    // completer completion stream
    output pcie_pkg::cc_beat_t cc_beat,
    output logic               cc_valid,
    input  logic               cc_ready
);

    import pcie_pkg::*;

    logic     cpl_req;
    cc_beat_t cpl_next;

    // request that is owed a completion
    assign cpl_req = req_stb & req.is_read;

    // busy from the strobe until the completion has left
    assign cpl_busy = cpl_req | cc_valid;

    always_comb begin
        cpl_next.lower_addr   = req.lower_addr;
        cpl_next.requester_id = req.requester_id;
        cpl_next.tag          = req.tag;

        if (req.unsupported) begin
            // UR carries no payload
            cpl_next.status      = cpl_status_ur;
            cpl_next.dword_count = 11'd0;
            cpl_next.byte_count  = 13'd0;
            cpl_next.data        = '0;
        end else begin
            cpl_next.status      = cpl_status_sc;
            cpl_next.dword_count = 11'd1;
            cpl_next.byte_count  = 13'd4;
            cpl_next.data        = rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_valid <= 1'b0;
        end else if (cpl_req) begin
            cc_valid <= 1'b1;
        end else if (cc_valid && cc_ready) begin
            cc_valid <= 1'b0;
        end
    end

    // completion payload, steady while cc_valid waits for cc_ready
    always_ff @(posedge clk) begin
        if (cpl_req) begin
            cc_beat <= cpl_next;
        end
    end

endmodule

// File: logic/pcie_core.sv
// PCIe endpoint user core, completer side
// serves BAR0 register reads and writes from the CQ stream

`timescale 1ns/10ps

module pcie_core (
    input  logic               clk,
    input  logic               rst_n,

    // completer request from the PCIe block
    input  pcie_pkg::cq_beat_t cq_beat,
    input  logic               cq_valid,
    output logic               cq_ready,

    // completer completion to the PCIe block
    output pcie_pkg::cc_beat_t cc_beat,
    output logic               cc_valid,
    input  logic               cc_ready,

    output logic               status_error_uncor
);

    import pcie_pkg::*;

    req_t        req;
    logic        req_stb;
    logic [31:0] rdata;
    logic        cpl_busy;

    pcie_cq_decode cq_decode_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .cq_beat            (cq_beat),
        .cq_valid           (cq_valid),
        .cq_ready           (cq_ready),
        .cpl_busy           (cpl_busy),
        .req                (req),
        .req_stb            (req_stb),
        .status_error_uncor (status_error_uncor)
    );

    bar_regs bar_regs_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .req_stb (req_stb),
        .rdata   (rdata)
    );

    pcie_cc_gen cc_gen_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_stb  (req_stb),
        .rdata    (rdata),
        .cpl_busy (cpl_busy),
        .cc_beat  (cc_beat),
        .cc_valid (cc_valid),
        .cc_ready (cc_ready)
    );

endmodule

// File: dv/tb_pcie_core.sv
// testbench for the PCIe completer core
// table of BAR0 requests checked against a register model

`timescale 1ns/10ps

`include "pcie_cfg.svh"

module tb_pcie_core;

    import pcie_pkg::*;

    // one table row with its expected response
    typedef struct packed {
        req_type_e   rtype;
        logic [2:0]  bar_id;
        logic [61:0] addr;
        logic [10:0] dword_count;
        logic [3:0]  first_be;
        logic [31:0] data;
        logic        exp_cpl;
        logic        exp_err;
        cc_beat_t    exp_beat;
    } entry_t;

    logic     clk;
    logic     rst_n;
    cq_beat_t cq_beat;
    logic     cq_valid;
    logic     cq_ready;
    cc_beat_t cc_beat;
    logic     cc_valid;
    logic     cc_ready;
    logic     status_error_uncor;

    entry_t table_q[$];

    // register model
    logic [31:0] m_scratch;
    logic [31:0] m_wr_count;
    logic [31:0] m_err_count;

    int err_pulses = 0;
    int cpl_seen = 0;
    int error_count = 0;
    int tests_failed = 0;
    int cur_test = 0;

    pcie_core UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .cq_beat            (cq_beat),
        .cq_valid           (cq_valid),
        .cq_ready           (cq_ready),
        .cc_beat            (cc_beat),
        .cc_valid           (cc_valid),
        .cc_ready           (cc_ready),
        .status_error_uncor (status_error_uncor)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // event counters sampled on the clock edge
    always @(posedge clk) begin
        if (rst_n && status_error_uncor) begin
            err_pulses = err_pulses + 1;
        end
        if (rst_n && cc_valid && cc_ready) begin
            cpl_seen = cpl_seen + 1;
        end
    end

    function automatic logic [31:0] model_read(input logic [9:0] idx);
        case (idx)
            `PCIE_REG_ADDR_ID:        model_read = `PCIE_REG_ID;
            `PCIE_REG_ADDR_SCRATCH:   model_read = m_scratch;
            `PCIE_REG_ADDR_WR_COUNT:  model_read = m_wr_count;
            `PCIE_REG_ADDR_ERR_COUNT: model_read = m_err_count;
            default:                  model_read = '0;
        endcase
    endfunction

    function automatic string type_name(input req_type_e t);
        case (t)
            req_mem_read:  type_name = "mem_read";
            req_mem_write: type_name = "mem_write";
            req_io_read:   type_name = "io_read";
            req_io_write:  type_name = "io_write";
            default:       type_name = "other";
        endcase
    endfunction

    // append a request with expected values from the model in table order
    task automatic add_req(input req_type_e rtype, input logic [2:0] bar_id,
                           input logic [61:0] addr, input logic [10:0] dword_count,
                           input logic [3:0] first_be, input logic [31:0] data);
        entry_t     e;
        logic       is_write;
        logic       bad;
        logic [9:0] idx;
        e = '0;
        e.rtype       = rtype;
        e.bar_id      = bar_id;
        e.addr        = addr;
        e.dword_count = dword_count;
        e.first_be    = first_be;
        e.data        = data;
        is_write = (rtype == req_mem_write) || (rtype == req_io_write);
        bad = !(rtype == req_mem_read || rtype == req_mem_write) || (bar_id != 3'd0) ||
              (dword_count != 11'd1) || (addr[61:10] != '0);
        idx = addr[9:0];
        e.exp_err = bad;
        e.exp_cpl = !is_write;
        e.exp_beat.tag          = 8'(table_q.size());
        e.exp_beat.requester_id = 16'h0a00 + 16'(table_q.size());
        e.exp_beat.lower_addr   = {addr[4:0], 2'b00};
        if (!is_write && bad) begin
            e.exp_beat.status = cpl_status_ur;
        end else if (!is_write) begin
            e.exp_beat.status      = cpl_status_sc;
            e.exp_beat.dword_count = 11'd1;
            e.exp_beat.byte_count  = 13'd4;
            e.exp_beat.data        = model_read(idx);
        end
        if (bad) begin
            m_err_count = m_err_count + 32'd1;
        end else if (is_write) begin
            m_wr_count = m_wr_count + 32'd1;
            if (idx == `PCIE_REG_ADDR_SCRATCH) begin
                for (int b = 0; b < 4; b++) begin
                    if (first_be[b]) begin
                        m_scratch[8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
        end
        table_q.push_back(e);
    endtask

    task automatic build_table();
        m_scratch   = '0;
        m_wr_count  = '0;
        m_err_count = '0;
        add_req(req_mem_read,  3'd0, 62'h0,   11'd1, 4'hf, 32'h0);
        // partial byte enables on scratch
        add_req(req_mem_write, 3'd0, 62'h1,   11'd1, 4'hf, 32'h1122_3344);
        add_req(req_mem_write, 3'd0, 62'h1,   11'd1, 4'h5, 32'haabb_ccdd);
        add_req(req_mem_read,  3'd0, 62'h1,   11'd1, 4'hf, 32'h0);
        // writes to the read-only ID still count
        add_req(req_mem_write, 3'd0, 62'h0,   11'd1, 4'hf, 32'hdead_beef);
        add_req(req_mem_write, 3'd0, 62'h0,   11'd1, 4'h3, 32'h0bad_f00d);
        add_req(req_mem_write, 3'd0, 62'h8,   11'd1, 4'hf, 32'h5555_aaaa);
        add_req(req_mem_read,  3'd0, 62'h2,   11'd1, 4'hf, 32'h0);
        add_req(req_mem_read,  3'd0, 62'h0,   11'd1, 4'hf, 32'h0);
        // unsupported requests
        add_req(req_io_read,   3'd0, 62'h1,   11'd1, 4'hf, 32'h0);
        add_req(req_io_write,  3'd0, 62'h1,   11'd1, 4'hf, 32'hffff_ffff);
        add_req(req_mem_read,  3'd2, 62'h1,   11'd1, 4'hf, 32'h0);
        add_req(req_mem_write, 3'd2, 62'h1,   11'd1, 4'hf, 32'h0101_0101);
        add_req(req_mem_read,  3'd0, 62'h401, 11'd1, 4'hf, 32'h0);
        add_req(req_mem_write, 3'd0, 62'h401, 11'd1, 4'hf, 32'h0202_0202);
        add_req(req_mem_read,  3'd0, 62'h1,   11'd2, 4'hf, 32'h0);
        add_req(req_mem_write, 3'd0, 62'h1,   11'd2, 4'hf, 32'h0303_0303);
        add_req(req_mem_read,  3'd0, 62'h1,   11'd1, 4'hf, 32'h0);
        add_req(req_mem_read,  3'd0, 62'h3,   11'd1, 4'hf, 32'h0);
        add_req(req_mem_read,  3'd0, 62'h2,   11'd1, 4'hf, 32'h0);
        add_req(req_mem_read,  3'd0, 62'h10,  11'd1, 4'hf, 32'h0);
        add_req(req_mem_read,  3'd0, 62'h1f,  11'd1, 4'hf, 32'h0);
    endtask

    task automatic check_cpl(input cc_beat_t got, input cc_beat_t exp);
        if (got.status !== exp.status) begin
            $display("Mismatch test %0d cc_beat.status: got 0x%h expected 0x%h",
                     cur_test, got.status, exp.status);
            error_count++;
        end
        if (got.dword_count !== exp.dword_count) begin
            $display("Mismatch test %0d cc_beat.dword_count: got 0x%h expected 0x%h",
                     cur_test, got.dword_count, exp.dword_count);
            error_count++;
        end
        if (got.byte_count !== exp.byte_count) begin
            $display("Mismatch test %0d cc_beat.byte_count: got 0x%h expected 0x%h",
                     cur_test, got.byte_count, exp.byte_count);
            error_count++;
        end
        if (got.tag !== exp.tag) begin
            $display("Mismatch test %0d cc_beat.tag: got 0x%h expected 0x%h",
                     cur_test, got.tag, exp.tag);
            error_count++;
        end
        if (got.requester_id !== exp.requester_id) begin
            $display("Mismatch test %0d cc_beat.requester_id: got 0x%h expected 0x%h",
                     cur_test, got.requester_id, exp.requester_id);
            error_count++;
        end
        if (got.lower_addr !== exp.lower_addr) begin
            $display("Mismatch test %0d cc_beat.lower_addr: got 0x%h expected 0x%h",
                     cur_test, got.lower_addr, exp.lower_addr);
            error_count++;
        end
        if (got.data !== exp.data) begin
            $display("Mismatch test %0d cc_beat.data: got 0x%h expected 0x%h",
                     cur_test, got.data, exp.data);
            error_count++;
        end
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch test %0d %s: got 0x%h expected 0x%h", cur_test, sig, got, exp);
            error_count++;
        end
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the transfer edge
    task automatic send_req(input cq_beat_t beat, output bit timed_out);
        int cycles;
        timed_out = 1'b0;
        cycles    = 0;
        cq_beat   = beat;
        cq_valid  = 1'b1;
        while (!cq_ready && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!cq_ready) begin
            $display("test %0d timed out waiting for cq_ready to accept the request", cur_test);
            error_count++;
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #1;
        end
        cq_valid = 1'b0;
    endtask

    task automatic receive_cpl(output cc_beat_t beat, output bit timed_out);
        int cycles;
        int stall;
        timed_out = 1'b0;
        beat      = '0;
        cycles    = 0;
        while (!cc_valid && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!cc_valid) begin
            $display("test %0d timed out waiting for cc_valid on a read", cur_test);
            error_count++;
            timed_out = 1'b1;
        end else begin
            stall = $urandom % 4;
            repeat (stall) begin
                // a held completion must keep new requests out
                check_flag("cq_ready", cq_ready, 1'b0);
                @(posedge clk);
                #1;
            end
            check_flag("cc_valid", cc_valid, 1'b1);
            beat     = cc_beat;
            cc_ready = 1'b1;
            @(posedge clk);
            #1;
            cc_ready = 1'b0;
        end
    endtask

    initial begin
        entry_t   e;
        cq_beat_t beat;
        cc_beat_t got;
        bit       timed_out;
        int       errors_before;
        int       pulses_before;
        int       cpl_before;
        int       reads;
        void'($urandom(61));
        rst_n    = 1'b0;
        cq_beat  = '0;
        cq_valid = 1'b0;
        cc_ready = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_flag("cq_ready", cq_ready, 1'b1);
        check_flag("cc_valid", cc_valid, 1'b0);
        check_flag("status_error_uncor", status_error_uncor, 1'b0);

        timed_out = 1'b0;
        reads     = 0;
        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            e             = table_q[i];
            cur_test      = i + 1;
            errors_before = error_count;
            pulses_before = err_pulses;
            cpl_before    = cpl_seen;
            beat              = '0;
            beat.addr         = e.addr;
            beat.dword_count  = e.dword_count;
            beat.req_type     = e.rtype;
            beat.requester_id = e.exp_beat.requester_id;
            beat.tag          = e.exp_beat.tag;
            beat.bar_id       = e.bar_id;
            beat.first_be     = e.first_be;
            beat.data         = e.data;
            send_req(beat, timed_out);
            if (!timed_out && e.exp_cpl) begin
                reads++;
                receive_cpl(got, timed_out);
                if (!timed_out) begin
                    check_cpl(got, e.exp_beat);
                end
            end else if (!timed_out) begin
                // a posted write gets no completion
                repeat (2) @(posedge clk);
                #1;
                check_flag("cc_valid", cc_valid, 1'b0);
            end
            if (!timed_out) begin
                check_flag("status_error_uncor", err_pulses != pulses_before, e.exp_err);
                if (err_pulses - pulses_before > 1) begin
                    $display("test %0d saw more than one error pulse", cur_test);
                    error_count++;
                end
                check_flag("completion transfer", (cpl_seen - cpl_before) == 1, e.exp_cpl);
            end
            if (error_count != errors_before) begin
                tests_failed++;
            end
            $display("test %0d %s bar %0d addr 0x%h: %s", cur_test, type_name(e.rtype),
                     e.bar_id, e.addr, (error_count == errors_before) ? "ok" : "failed");
        end

        if (!timed_out && cpl_seen != reads) begin
            $display("completion count is %0d but %0d reads were sent", cpl_seen, reads);
            error_count++;
        end
        $display("tests %0d, failed %0d, errors %0d", table_q.size(), tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/pcie_pkg.sv
logic/pcie_cq_decode.sv
logic/bar_regs.sv
logic/pcie_cc_gen.sv
logic/pcie_core.sv
dv/tb_pcie_core.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat verilog.f))

.PHONY: all run clean

all: obj_dir/Vtb_pcie_core

obj_dir/Vtb_pcie_core: verilog.f $(SRCS) logic/pcie_cfg.svh
	verilator --binary --timing -f verilog.f --top-module tb_pcie_core -Mdir obj_dir

run: obj_dir/Vtb_pcie_core
	./obj_dir/Vtb_pcie_core > sim.log 2>&1
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log
